// File: filelist.f
common/lsu_pkg.sv
hdl/lsu_fifo.sv
lsu/lsu_core.sv
dmem/dmem_bank.sv
hdl/lsu_subsys_top.sv
testbench/lsu_tb.sv

// File: testbench/lsu_tb.sv
// LSU subsystem testbench; bank fixed at 64 words, expected results come from a byte-array model
module lsu_tb
    import lsu_pkg::*;
;

    localparam int CMD_DEPTH = 4;
    localparam int RES_DEPTH = 4;
    localparam int MEM_WORDS = 64;
    localparam int RESP_LAT  = 2;
    localparam int MEM_BYTES = MEM_WORDS * 4;
    localparam int TIMEOUT   = 200;             // Cycles per wait loop

    logic     clk = 1'b0;
    logic     rst_n;
    logic     cmd_valid_i;
    lsu_cmd_s cmd_i;
    logic     cmd_ready_o;
    logic     res_valid_o;
    lsu_res_s res_o;
    logic     res_ready_i;

    logic [31:0] lcg_state = 32'd16917;
    logic [7:0]  model_mem [MEM_BYTES];         // Reference byte memory
    lsu_res_s    exp_q [$];                     // Expected results, command order
    string       name_q [$];
    string       test_name;
    logic        cmd_acc;                       // Handshakes seen at last edge
    logic        res_acc;

    always #4 clk = ~clk;

    lsu_subsys_top #(
        .CMD_DEPTH(CMD_DEPTH), .RES_DEPTH(RES_DEPTH),
        .MEM_WORDS(MEM_WORDS), .RESP_LAT(RESP_LAT)
    ) lsu_subsys_top_inst (
        .clk, .rst_n,
        .cmd_valid_i, .cmd_i, .cmd_ready_o,
        .res_valid_o, .res_o, .res_ready_i
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];                // Upper half, better spread
    endfunction

    function automatic lsu_cmd_s rand_cmd();
        lsu_cmd_s    c;
        logic [15:0] r;
        r    = lcg_next();
        c.op = lsu_op_e'(4'd1 + 4'(r[2:0]));    // LB through SW
        r    = lcg_next();
        if (r[2:0] == 3'd0) begin
            c.addr = 32'(MEM_BYTES) + 32'(r[15:6]); // Beyond the bank
        end else begin
            c.addr = {24'd0, r[15:8]};
        end
        c.sdata = {lcg_next(), lcg_next()};
        return c;
    endfunction

    // Reference model of unit plus bank, applied in acceptance order
    function automatic lsu_res_s model_exec(input lsu_cmd_s c);
        lsu_res_s    r;
        int          nbytes;
        logic        is_st;
        logic [31:0] w;
        r     = '0;
        w     = '0;
        is_st = (c.op == LSU_OP_SB) || (c.op == LSU_OP_SH) || (c.op == LSU_OP_SW);
        case (c.op)
            LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB: nbytes = 1;
            LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: nbytes = 2;
            default:                          nbytes = 4;
        endcase
        if ((nbytes == 2 && c.addr[0]) || (nbytes == 4 && c.addr[1:0] != 2'b00)) begin
            r.exc      = 1'b1;                  // Misalign wins over range
            r.exc_code = is_st ? EXC_ST_ADDR_MISALIGN : EXC_LD_ADDR_MISALIGN;
        end else if (c.addr >= 32'(MEM_BYTES)) begin
            r.exc      = 1'b1;
            r.exc_code = is_st ? EXC_ST_ACCESS_FAULT : EXC_LD_ACCESS_FAULT;
        end else if (is_st) begin
            for (int i = 0; i < nbytes; i++) begin
                model_mem[c.addr + i] = c.sdata[8*i +: 8];
            end
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                w[8*i +: 8] = model_mem[c.addr + i];
            end
            case (c.op)
                LSU_OP_LB:  r.ldata = {{24{w[7]}}, w[7:0]};
                LSU_OP_LBU: r.ldata = {24'd0, w[7:0]};
                LSU_OP_LH:  r.ldata = {{16{w[15]}}, w[15:0]};
                LSU_OP_LHU: r.ldata = {16'd0, w[15:0]};
                default:    r.ldata = w;
            endcase
        end
        return r;
    endfunction

    // One clock edge; handshakes sampled with pre-edge values
    task automatic step_clock();
        lsu_res_s exp;
        string    nm;
        @(posedge clk);
        cmd_acc = cmd_valid_i && cmd_ready_o;
        res_acc = res_valid_o && res_ready_i;
        if (res_acc) begin
            assert (exp_q.size() > 0) else abort_run("Result delivered with no command outstanding");
            exp = exp_q.pop_front();
            nm  = name_q.pop_front();
            assert (res_o == exp) else
                abort_run($sformatf("CHECK FAILED %s: expected %h actual %h", nm, exp, res_o));
        end
        if (cmd_acc) begin
            exp_q.push_back(model_exec(cmd_i));
            name_q.push_back(test_name);
        end
    endtask

    task automatic send_cmd(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] sd);
        lsu_cmd_s c;
        int       cnt;
        c.op        = op;
        c.addr      = addr;
        c.sdata     = sd;
        cnt         = 0;
        cmd_i       <= c;
        cmd_valid_i <= 1'b1;
        do begin
            step_clock();
            cnt++;
            assert (cnt <= TIMEOUT) else abort_run("Timeout: command never accepted");
        end while (!cmd_acc);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic drain_results();
        int cnt;
        cnt         = 0;
        cmd_valid_i <= 1'b0;
        res_ready_i <= 1'b1;
        while (exp_q.size() != 0) begin
            step_clock();
            cnt++;
            assert (cnt <= TIMEOUT) else abort_run("Timeout: pending results did not drain");
        end
        step_clock();                           // An extra result finds no model entry
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        lsu_cmd_s c;
        int       wait_cnt;
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        res_ready_i = 1'b0;
        test_name   = "reset";
        for (int i = 0; i < MEM_BYTES; i++) model_mem[i] = 8'h00;
        repeat (10) @(posedge clk);
        assert (cmd_ready_o && !res_valid_o) else abort_run("Wrong handshake outputs in reset");
        rst_n       <= 1'b1;
        res_ready_i <= 1'b1;

        // Store then load, every width and extension
        test_name = "store_load";
        send_cmd(LSU_OP_SW, 32'h20, 32'h80FF_7F01);
        send_cmd(LSU_OP_LB, 32'h20, 32'h0);
        send_cmd(LSU_OP_LB, 32'h23, 32'h0);     // 0x80, negative
        send_cmd(LSU_OP_LBU, 32'h23, 32'h0);
        send_cmd(LSU_OP_LH, 32'h22, 32'h0);
        send_cmd(LSU_OP_LHU, 32'h22, 32'h0);
        send_cmd(LSU_OP_LW, 32'h20, 32'h0);
        send_cmd(LSU_OP_SB, 32'h25, 32'h1234_56A5); // Upper bytes ignored
        send_cmd(LSU_OP_LBU, 32'h25, 32'h0);
        send_cmd(LSU_OP_SH, 32'h26, 32'hDEAD_9234);
        send_cmd(LSU_OP_LH, 32'h26, 32'h0);
        send_cmd(LSU_OP_LW, 32'h24, 32'h0);
        drain_results();

        // Misaligned accesses, memory must stay intact
        test_name = "misalign";
        send_cmd(LSU_OP_LH, 32'h21, 32'h0);
        send_cmd(LSU_OP_LHU, 32'h23, 32'h0);
        send_cmd(LSU_OP_LW, 32'h22, 32'h0);
        send_cmd(LSU_OP_SH, 32'h25, 32'hFFFF_FFFF);
        send_cmd(LSU_OP_SW, 32'h27, 32'hFFFF_FFFF);
        send_cmd(LSU_OP_LW, 32'h20, 32'h0);
        send_cmd(LSU_OP_LW, 32'h24, 32'h0);
        drain_results();

        // Out of range, the bank index would alias onto words 0 and 1
        test_name = "range";
        send_cmd(LSU_OP_SW, 32'h100, 32'hCAFE_F00D);
        send_cmd(LSU_OP_LW, 32'h100, 32'h0);
        send_cmd(LSU_OP_LB, 32'h1FF, 32'h0);
        send_cmd(LSU_OP_LHU, 32'h3FE, 32'h0);
        send_cmd(LSU_OP_SB, 32'h104, 32'h77);
        send_cmd(LSU_OP_LW, 32'h0, 32'h0);
        send_cmd(LSU_OP_LW, 32'h4, 32'h0);
        send_cmd(LSU_OP_LW, 32'hFC, 32'h0);     // Last valid word
        drain_results();

        // Random traffic with random valid and ready
        test_name = "random";
        for (int n = 0; n < 400; n++) begin
            c        = rand_cmd();
            cmd_i    <= c;
            wait_cnt = 0;
            do begin
                cmd_valid_i <= (lcg_next() % 4) != 0;
                res_ready_i <= (lcg_next() % 3) != 0;
                step_clock();
                wait_cnt++;
                assert (wait_cnt <= TIMEOUT) else abort_run("Timeout: random command stalled");
            end while (!cmd_acc);
        end
        drain_results();

        // Back-pressure, both queues fill and nothing is lost
        test_name   = "backpressure";
        res_ready_i <= 1'b0;
        cmd_valid_i <= 1'b1;
        cmd_i       <= rand_cmd();
        wait_cnt    = 0;
        do begin
            step_clock();
            if (cmd_acc) cmd_i <= rand_cmd();
            wait_cnt++;
            assert (wait_cnt <= TIMEOUT) else abort_run("Timeout: queues never filled");
        end while (cmd_ready_o || exp_q.size() < CMD_DEPTH + RES_DEPTH);
        cmd_valid_i <= 1'b0;
        assert (exp_q.size() == CMD_DEPTH + RES_DEPTH) else
            abort_run($sformatf("CHECK FAILED backpressure: expected %0d actual %0d",
                                CMD_DEPTH + RES_DEPTH, exp_q.size()));
        drain_results();

        $display("Test completed successfully");
        $finish;
    end

endmodule : lsu_tb

// File: hdl/lsu_subsys_top.sv
// Load/store subsystem top; results leave in command order, latency depends on queue occupancy
module lsu_subsys_top
    import lsu_pkg::*;
#(
    parameter int CMD_DEPTH = 4,            // Command queue entries
    parameter int RES_DEPTH = 4,            // Result queue entries
    parameter int MEM_WORDS = 256,
    parameter int RESP_LAT  = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid_i,
    input  lsu_cmd_s cmd_i,
    output logic     cmd_ready_o,
    output logic     res_valid_o,
    output lsu_res_s res_o,
    input  logic     res_ready_i
);

    // ----------------------------------------------------------
    // Interconnect
    // ----------------------------------------------------------
    logic            cmd_full;
    logic            cmd_empty;
    logic            cmd_pop;
    lsu_cmd_s        cmd_head;              // Command under execution
    logic            res_full;
    logic            res_empty;
    logic            res_push;
    lsu_res_s        res_in;
    logic            dmem_req;
    dmem_req_s       dmem_req_pkt;
    logic            dmem_ack;
    mem_resp_e       dmem_resp;
    logic [XLEN-1:0] dmem_rdata;

    assign cmd_ready_o = ~cmd_full;
    assign res_valid_o = ~res_empty;

    lsu_fifo #(.DEPTH(CMD_DEPTH), .T(lsu_cmd_s)) cmd_fifo_inst (
        .clk, .rst_n,
        .push_i (cmd_valid_i & cmd_ready_o), .data_i (cmd_i), .pop_i (cmd_pop),
        .data_o (cmd_head), .full_o (cmd_full), .empty_o (cmd_empty)
    );

    lsu_core lsu_core_inst (
        .clk, .rst_n,
        .cmd_valid_i (~cmd_empty), .cmd_i (cmd_head), .cmd_pop_o (cmd_pop),
        .res_full_i (res_full), .res_push_o (res_push), .res_o (res_in),
        .dmem_req_o (dmem_req), .dmem_req_s_o (dmem_req_pkt), .dmem_ack_i (dmem_ack),
        .dmem_resp_i (dmem_resp), .dmem_rdata_i (dmem_rdata)
    );

    dmem_bank #(.MEM_WORDS(MEM_WORDS), .RESP_LAT(RESP_LAT)) dmem_bank_inst (
        .clk, .rst_n,
        .req_i (dmem_req), .req_s_i (dmem_req_pkt),
        .ack_o (dmem_ack), .resp_o (dmem_resp), .rdata_o (dmem_rdata)
    );

    lsu_fifo #(.DEPTH(RES_DEPTH), .T(lsu_res_s)) res_fifo_inst (
        .clk, .rst_n,
        .push_i (res_push), .data_i (res_in), .pop_i (res_valid_o & res_ready_i),
        .data_o (res_o), .full_o (res_full), .empty_o (res_empty)
    );

endmodule : lsu_subsys_top

// File: dmem/dmem_bank.sv
// Word-array data memory, one access in flight; RESP_LAT must be at least 1, misaligned requests not expected
module dmem_bank
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS = 256,          // Bank size in words
    parameter int RESP_LAT  = 2             // Cycles from accept to response
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_i,
    input  dmem_req_s       req_s_i,
    output logic            ack_o,          // Free to accept
    output mem_resp_e       resp_o,
    output logic [XLEN-1:0] rdata_o         // Shifted down to bit 0
);

    localparam int AW    = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(RESP_LAT + 1);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic             pending;              // Access in flight
    logic [CNT_W-1:0] cnt;                  // Cycles left to response
    logic             err_ff;               // Latched range fault
    logic [XLEN-1:0]  rdata_ff;

    logic             accept;
    logic             in_range;
    logic [AW-1:0]    idx;
    logic [4:0]       sh;                   // 8 * addr[1:0]
    logic [3:0]       be_base;
    logic [3:0]       be;                   // Byte lanes to write
    logic [XLEN-1:0]  wdata_sh;

    // ----------------------------------------------------------
    // Address decode and lane alignment
    // ----------------------------------------------------------
    assign accept   = req_i & ack_o;
    assign in_range = ({2'b00, req_s_i.addr[XLEN-1:2]} < XLEN'(MEM_WORDS));
    assign idx      = req_s_i.addr[AW+1:2];
    assign sh       = {req_s_i.addr[1:0], 3'b000};

    always_comb begin
        case (req_s_i.width)
            MEM_WIDTH_BYTE:  be_base = 4'b0001;
            MEM_WIDTH_HWORD: be_base = 4'b0011;
            default:         be_base = 4'b1111;
        endcase
    end

    assign be       = be_base << req_s_i.addr[1:0];  // Lanes past bit 31 dropped
    assign wdata_sh = req_s_i.wdata << sh;

    // ----------------------------------------------------------
    // Array, write at acceptance
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && in_range && (req_s_i.cmd == MEM_CMD_WR)) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
            end
        end
    end

    // Read data captured at acceptance, held until response
    always_ff @(posedge clk) begin
        if (accept && in_range && (req_s_i.cmd == MEM_CMD_RD)) begin
            rdata_ff <= mem[idx] >> sh;
        end
    end

    // ----------------------------------------------------------
    // Response timer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            cnt     <= '0;
            err_ff  <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
            cnt     <= CNT_W'(RESP_LAT - 1);
            err_ff  <= ~in_range;
        end else if (pending) begin
            if (cnt == '0) pending <= 1'b0; // Response cycle ends
            else           cnt     <= cnt - 1'b1;
        end
    end

    assign ack_o   = ~pending;
    assign resp_o  = (pending && cnt == '0) ? (err_ff ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK)
                                            : MEM_RESP_IDLE;
    assign rdata_o = rdata_ff;

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    a_lat_min : assert property (
        @(posedge clk) RESP_LAT >= 1
    ) else $error("DMEM: RESP_LAT below 1");

    a_resp_timing : assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> ##RESP_LAT (resp_o != MEM_RESP_IDLE) ##1 (resp_o == MEM_RESP_IDLE)
    ) else $error("DMEM: response not one cycle at RESP_LAT");

endmodule : dmem_bank

// File: lsu/lsu_core.sv
// Load/store unit, one access in flight; head command is held by the queue until popped
module lsu_core
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Command queue side
    input  logic      cmd_valid_i,          // Queue not empty
    input  lsu_cmd_s  cmd_i,                // Head command
    output logic      cmd_pop_o,            // Command finished
    // Result queue side
    input  logic      res_full_i,
    output logic      res_push_o,
    output lsu_res_s  res_o,
    // Data memory side
    output logic      dmem_req_o,
    output dmem_req_s dmem_req_s_o,
    input  logic      dmem_ack_i,
    input  mem_resp_e dmem_resp_i,
    input  logic [XLEN-1:0] dmem_rdata_i    // Already lane-shifted
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1                      // Waiting for memory response
    } state_e;

    state_e     state;
    state_e     state_nxt;
    logic       idle;
    lsu_op_e    op_ff;                      // Opcode of access in flight

    logic       is_load;
    logic       is_store;
    mem_width_e width;
    logic       mslgn;                      // Head misaligned while idle
    logic       mslgn_l;
    logic       mslgn_s;
    logic       exc_push;                   // Misalign result this cycle
    logic       req_acc;                    // Request accepted by bank
    logic       resp_ok;
    logic       resp_er;
    logic       resp_rcvd;
    logic       op_ff_store;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        width    = MEM_WIDTH_WORD;          // Also covers unknown opcodes
        case (cmd_i.op)
            LSU_OP_LB, LSU_OP_LBU: begin
                is_load = 1'b1;
                width   = MEM_WIDTH_BYTE;
            end
            LSU_OP_LH, LSU_OP_LHU: begin
                is_load = 1'b1;
                width   = MEM_WIDTH_HWORD;
            end
            LSU_OP_LW: is_load = 1'b1;
            LSU_OP_SB: begin
                is_store = 1'b1;
                width    = MEM_WIDTH_BYTE;
            end
            LSU_OP_SH: begin
                is_store = 1'b1;
                width    = MEM_WIDTH_HWORD;
            end
            LSU_OP_SW: is_store = 1'b1;
            default: ;
        endcase
    end

    // Alignment, only meaningful for the head while idle
    assign mslgn   = idle & cmd_valid_i
                   & (((width == MEM_WIDTH_HWORD) & cmd_i.addr[0])
                   |  ((width == MEM_WIDTH_WORD)  & (|cmd_i.addr[1:0])));
    assign mslgn_l = mslgn & is_load;
    assign mslgn_s = mslgn & is_store;

    // ----------------------------------------------------------
    // FSM and opcode register
    // ----------------------------------------------------------
    assign idle      = (state == ST_IDLE);
    assign resp_ok   = (dmem_resp_i == MEM_RESP_RDY_OK);
    assign resp_er   = (dmem_resp_i == MEM_RESP_RDY_ER);
    assign resp_rcvd = resp_ok | resp_er;
    assign req_acc   = dmem_req_o & dmem_ack_i;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (req_acc)   state_nxt = ST_BUSY;
            ST_BUSY: if (resp_rcvd) state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            op_ff <= LSU_OP_NONE;
        end else begin
            state <= state_nxt;
            if (req_acc) op_ff <= cmd_i.op; // Latched on acceptance
        end
    end

    assign op_ff_store = (op_ff == LSU_OP_SB) | (op_ff == LSU_OP_SH) | (op_ff == LSU_OP_SW);

    // ----------------------------------------------------------
    // Memory request and result
    // ----------------------------------------------------------
    // Request only when a result slot is guaranteed
    assign dmem_req_o         = idle & cmd_valid_i & ~mslgn & ~res_full_i;
    assign dmem_req_s_o.cmd   = is_store ? MEM_CMD_WR : MEM_CMD_RD;
    assign dmem_req_s_o.width = width;
    assign dmem_req_s_o.addr  = cmd_i.addr;
    assign dmem_req_s_o.wdata = cmd_i.sdata;

    assign exc_push   = (mslgn_l | mslgn_s) & ~res_full_i;
    assign res_push_o = exc_push | resp_rcvd;
    assign cmd_pop_o  = res_push_o;         // Head retires with its result

    always_comb begin
        res_o.exc = resp_er | mslgn_l | mslgn_s;
        // Exception code, response error takes the registered opcode
        if (resp_er) begin
            res_o.exc_code = op_ff_store ? EXC_ST_ACCESS_FAULT : EXC_LD_ACCESS_FAULT;
        end else if (mslgn_l) begin
            res_o.exc_code = EXC_LD_ADDR_MISALIGN;
        end else if (mslgn_s) begin
            res_o.exc_code = EXC_ST_ADDR_MISALIGN;
        end else begin
            res_o.exc_code = EXC_NONE;
        end
        // Load extension
        res_o.ldata = '0;
        if (resp_ok) begin
            case (op_ff)
                LSU_OP_LB:  res_o.ldata = {{24{dmem_rdata_i[7]}}, dmem_rdata_i[7:0]};
                LSU_OP_LBU: res_o.ldata = {24'b0, dmem_rdata_i[7:0]};
                LSU_OP_LH:  res_o.ldata = {{16{dmem_rdata_i[15]}}, dmem_rdata_i[15:0]};
                LSU_OP_LHU: res_o.ldata = {16'b0, dmem_rdata_i[15:0]};
                LSU_OP_LW:  res_o.ldata = dmem_rdata_i;
                default:    res_o.ldata = '0;  // Stores
            endcase
        end
    end

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    a_no_resp_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        idle |-> !resp_rcvd
    ) else $error("LSU: memory response while idle");

    a_exc_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({resp_er, mslgn_l, mslgn_s})
    ) else $error("LSU: more than one exception source");

    a_req_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem_req_o |-> !$isunknown(dmem_req_s_o)
    ) else $error("LSU: unknown request fields");

endmodule : lsu_core

// File: hdl/lsu_fifo.sv
// Circular buffer with type-parameterized payload; DEPTH must be at least 2, no push when full unless popping
module lsu_fifo #(
    parameter int  DEPTH = 4,               // Number of entries
    parameter type T     = logic            // Payload type
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push_i,                    // Write data_i at tail
    input  T     data_i,
    input  logic pop_i,                     // Drop head entry
    output T     data_o,                    // Head entry
    output logic full_o,
    output logic empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ----------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------
    T                 mem [DEPTH];          // Payload array
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                // Occupied entries

    // Pointer advance with wrap, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_i)  rd_ptr <= ptr_inc(rd_ptr);
            // Occupancy, simultaneous push and pop cancel
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;          // Head read before overwrite when full
        end
    end

    assign data_o  = mem[rd_ptr];           // Visible the cycle after push
    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        (push_i && full_o) |-> pop_i
    ) else $error("FIFO: push into full queue");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o
    ) else $error("FIFO: pop from empty queue");

endmodule : lsu_fifo

// File: common/lsu_pkg.sv
// Shared LSU types; XLEN fixed at 32, opcode and exception encodings follow RISC-V numbering
package lsu_pkg;

    // ----------------------------------------------------------
    // Constants
    // ----------------------------------------------------------
    parameter int XLEN = 32;                // Data and address width

    // ----------------------------------------------------------
    // Enumerations
    // ----------------------------------------------------------

    // Load/store opcode, NONE only seen after reset
    typedef enum logic [3:0] {
        LSU_OP_NONE = 4'd0,
        LSU_OP_LB   = 4'd1,                 // Byte, sign-extended
        LSU_OP_LBU  = 4'd2,                 // Byte, zero-extended
        LSU_OP_LH   = 4'd3,                 // Half, sign-extended
        LSU_OP_LHU  = 4'd4,                 // Half, zero-extended
        LSU_OP_LW   = 4'd5,
        LSU_OP_SB   = 4'd6,
        LSU_OP_SH   = 4'd7,
        LSU_OP_SW   = 4'd8
    } lsu_op_e;

    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response is valid for a single cycle
    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10             // Range fault in the bank
    } mem_resp_e;

    // RISC-V mcause numbering
    typedef enum logic [3:0] {
        EXC_NONE             = 4'd0,
        EXC_LD_ADDR_MISALIGN = 4'd4,
        EXC_LD_ACCESS_FAULT  = 4'd5,
        EXC_ST_ADDR_MISALIGN = 4'd6,
        EXC_ST_ACCESS_FAULT  = 4'd7
    } exc_code_e;

    // ----------------------------------------------------------
    // Packed structs
    // ----------------------------------------------------------
    typedef struct packed {
        lsu_op_e           op;
        logic [XLEN-1:0]   addr;            // Byte address
        logic [XLEN-1:0]   sdata;           // Store data, low bits used
    } lsu_cmd_s;

    typedef struct packed {
        mem_cmd_e          cmd;
        mem_width_e        width;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;           // Unshifted, bank aligns lanes
    } dmem_req_s;

    typedef struct packed {
        logic [XLEN-1:0]   ldata;           // Zero for stores and exceptions
        logic              exc;
        exc_code_e         exc_code;
    } lsu_res_s;

endpackage : lsu_pkg
